// ==== source/cmd_proc_pkg.sv ====
package cmd_proc_pkg;

  // Word widths
  localparam int CMD_W = 20;
  localparam int OPD_W = 8;
  localparam int OPC_W = 4;
  localparam int DEC_W = 20;
  localparam int RES_W = 11;

  // Buffer depths, powers of two
  localparam int OP_FIFO_DEPTH  = 4;
  localparam int RES_FIFO_DEPTH = 8;

  // Host command word fields
  localparam int OPC_MSB = 19;
  localparam int OPC_LSB = 16;
  localparam int OPA_MSB = 15;
  localparam int OPA_LSB = 8;
  localparam int OPB_MSB = 7;
  localparam int OPB_LSB = 0;

  // Decoded entry, operands sit where they sit in the command word
  localparam int DEC_OP_MSB  = 19;
  localparam int DEC_OP_LSB  = 17;
  localparam int DEC_ERR_BIT = 16;

  // Result word fields
  localparam int RES_ERR_BIT   = 10;
  localparam int RES_CARRY_BIT = 9;
  localparam int RES_ZERO_BIT  = 8;
  localparam int RES_DATA_MSB  = 7;
  localparam int RES_DATA_LSB  = 0;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SHL = 3'd5,
    OP_SHR = 3'd6
  } alu_op_e;

  typedef enum logic [1:0] {
    DEC_IDLE = 2'd0,
    DEC_ACK  = 2'd1,
    DEC_DROP = 2'd2
  } dec_state_e;

  typedef enum logic [1:0] {
    RES_IDLE = 2'd0,
    RES_REQ  = 2'd1,
    RES_DROP = 2'd2
  } res_state_e;

endpackage

// ==== source/fifo.sv ====
`timescale 1ns/1ps

module fifo #(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic [DATA_WIDTH-1:0] data_i,
  output logic [DATA_WIDTH-1:0] data_o,

  input  logic                  wr_valid_i,
  input  logic                  rd_valid_i,

  output logic                  empty_o,
  output logic                  full_o
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // Pointers carry one extra wrap bit above the address
  logic [ADDR_W:0]   wr_ptr;
  logic [ADDR_W:0]   rd_ptr;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic              wr_en;
  logic              rd_en;

  assign wr_addr = wr_ptr[ADDR_W-1:0];
  assign rd_addr = rd_ptr[ADDR_W-1:0];

  // Same address, same lap means empty; same address, other lap means full
  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_addr == rd_addr) && (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

  assign wr_en = wr_valid_i && !full_o;
  assign rd_en = rd_valid_i && !empty_o;

  // Head entry shown without a register stage
  assign data_o = mem[rd_addr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// ==== source/cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode
  import cmd_proc_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,

  // Host side, four-phase
  input  logic             in_req_i,
  input  logic [CMD_W-1:0] in_cmd_i,
  output logic             in_ack_o,

  // Decoded operation FIFO
  output logic             op_wr_valid_o,
  output logic [DEC_W-1:0] op_data_o,
  input  logic             op_full_i
);

  dec_state_e state;
  logic       ack_q;
  logic [OPC_W-1:0] opcode;
  logic [OPD_W-1:0] opd_a;
  logic [OPD_W-1:0] opd_b;
  alu_op_e          op;
  logic             err;

  assign opcode = in_cmd_i[OPC_MSB:OPC_LSB];
  assign opd_a  = in_cmd_i[OPA_MSB:OPA_LSB];
  assign opd_b  = in_cmd_i[OPB_MSB:OPB_LSB];

  // Opcode check, 7 to 15 travel on with the error bit set
  always_comb begin
    err = 1'b0;
    case (opcode)
      4'd0:    op = OP_ADD;
      4'd1:    op = OP_SUB;
      4'd2:    op = OP_AND;
      4'd3:    op = OP_OR;
      4'd4:    op = OP_XOR;
      4'd5:    op = OP_SHL;
      4'd6:    op = OP_SHR;
      default: begin
        op  = OP_ADD;
        err = 1'b1;
      end
    endcase
  end

  always_comb begin
    op_data_o = '0;
    op_data_o[DEC_OP_MSB:DEC_OP_LSB] = op;
    op_data_o[DEC_ERR_BIT]           = err;
    op_data_o[OPA_MSB:OPA_LSB]       = opd_a;
    op_data_o[OPB_MSB:OPB_LSB]       = opd_b;
  end

  // Word taken on the same edge that raises the ack
  assign op_wr_valid_o = (state == DEC_IDLE) && in_req_i && !op_full_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= DEC_IDLE;
      ack_q <= 1'b0;
    end else begin
      case (state)
        DEC_IDLE: begin
          // Full FIFO holds the ack back
          if (op_wr_valid_o) begin
            ack_q <= 1'b1;
            state <= DEC_ACK;
          end
        end
        DEC_ACK: begin
          if (!in_req_i) begin
            ack_q <= 1'b0;
            state <= DEC_DROP;
          end
        end
        // Ack is low again, one cycle before the next word
        DEC_DROP: state <= DEC_IDLE;
        default:  state <= DEC_IDLE;
      endcase
    end
  end

  assign in_ack_o = ack_q;

endmodule

// ==== source/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute
  import cmd_proc_pkg::*;
(
  // Decoded operation FIFO
  input  logic [DEC_W-1:0] op_data_i,
  input  logic             op_empty_i,
  output logic             op_rd_valid_o,

  // Result FIFO
  output logic             res_wr_valid_o,
  output logic [RES_W-1:0] res_data_o,
  input  logic             res_full_i
);

  alu_op_e          op;
  logic             err;
  logic [OPD_W-1:0] opd_a;
  logic [OPD_W-1:0] opd_b;
  logic [OPD_W:0]   sum;
  logic [OPD_W-1:0] data;
  logic             carry;

  assign op    = alu_op_e'(op_data_i[DEC_OP_MSB:DEC_OP_LSB]);
  assign err   = op_data_i[DEC_ERR_BIT];
  assign opd_a = op_data_i[OPA_MSB:OPA_LSB];
  assign opd_b = op_data_i[OPB_MSB:OPB_LSB];

  // Pop and push together when both sides allow it
  assign op_rd_valid_o  = !op_empty_i && !res_full_i;
  assign res_wr_valid_o = op_rd_valid_o;

  assign sum = {1'b0, opd_a} + {1'b0, opd_b};

  always_comb begin
    carry = 1'b0;
    case (op)
      OP_ADD: begin
        data  = sum[OPD_W-1:0];
        carry = sum[OPD_W];
      end
      OP_SUB: begin
        data  = opd_a - opd_b;
        carry = (opd_a < opd_b);
      end
      OP_AND:  data = opd_a & opd_b;
      OP_OR:   data = opd_a | opd_b;
      OP_XOR:  data = opd_a ^ opd_b;
      OP_SHL:  data = opd_a << opd_b[2:0];
      OP_SHR:  data = opd_a >> opd_b[2:0];
      default: data = '0;
    endcase
  end

  always_comb begin
    res_data_o = '0;
    if (err) begin
      // Error result carries no data and no flags
      res_data_o[RES_ERR_BIT] = 1'b1;
    end else begin
      res_data_o[RES_CARRY_BIT]              = carry;
      res_data_o[RES_ZERO_BIT]               = (data == '0);
      res_data_o[RES_DATA_MSB:RES_DATA_LSB]  = data;
    end
  end

endmodule

// ==== source/result_stage.sv ====
`timescale 1ns/1ps

module result_stage
  import cmd_proc_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,

  // From the execute stage
  input  logic             res_wr_valid_i,
  input  logic [RES_W-1:0] res_data_i,
  output logic             res_full_o,

  // Consumer side, four-phase
  output logic             out_req_o,
  output logic [RES_W-1:0] out_res_o,
  input  logic             out_ack_i
);

  res_state_e       state;
  logic             req_q;
  logic [RES_W-1:0] res_q;
  logic [RES_W-1:0] head;
  logic             empty;
  logic             pop;

  fifo #(
    .DATA_WIDTH (RES_W),
    .FIFO_DEPTH (RES_FIFO_DEPTH)
  ) res_fifo_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_i     (res_data_i),
    .data_o     (head),
    .wr_valid_i (res_wr_valid_i),
    .rd_valid_i (pop),
    .empty_o    (empty),
    .full_o     (res_full_o)
  );

  // One result in flight at a time
  assign pop = (state == RES_IDLE) && !empty;

  // Output register, loaded only on a pop
  always_ff @(posedge clk) begin
    if (pop) begin
      res_q <= head;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RES_IDLE;
      req_q <= 1'b0;
    end else begin
      case (state)
        RES_IDLE: begin
          if (pop) begin
            req_q <= 1'b1;
            state <= RES_REQ;
          end
        end
        RES_REQ: begin
          // Hold req and data until the consumer acks
          if (out_ack_i) begin
            req_q <= 1'b0;
            state <= RES_DROP;
          end
        end
        RES_DROP: begin
          if (!out_ack_i) begin
            state <= RES_IDLE;
          end
        end
        default: state <= RES_IDLE;
      endcase
    end
  end

  assign out_req_o = req_q;
  assign out_res_o = res_q;

endmodule

// ==== source/cmd_proc.sv ====
`timescale 1ns/1ps

module cmd_proc
  import cmd_proc_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,

  // Host command handshake
  input  logic             in_req_i,
  input  logic [CMD_W-1:0] in_cmd_i,
  output logic             in_ack_o,

  // Consumer result handshake
  output logic             out_req_o,
  output logic [RES_W-1:0] out_res_o,
  input  logic             out_ack_i
);

  // Decode to operation FIFO
  logic             op_wr_valid;
  logic [DEC_W-1:0] op_wr_data;
  logic             op_full;

  // Operation FIFO to execute
  logic [DEC_W-1:0] op_rd_data;
  logic             op_empty;
  logic             op_rd_valid;

  // Execute to result stage
  logic             res_wr_valid;
  logic [RES_W-1:0] res_wr_data;
  logic             res_full;

  cmd_decode cmd_decode_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_req_i      (in_req_i),
    .in_cmd_i      (in_cmd_i),
    .in_ack_o      (in_ack_o),
    .op_wr_valid_o (op_wr_valid),
    .op_data_o     (op_wr_data),
    .op_full_i     (op_full)
  );

  fifo #(
    .DATA_WIDTH (DEC_W),
    .FIFO_DEPTH (OP_FIFO_DEPTH)
  ) op_fifo_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_i     (op_wr_data),
    .data_o     (op_rd_data),
    .wr_valid_i (op_wr_valid),
    .rd_valid_i (op_rd_valid),
    .empty_o    (op_empty),
    .full_o     (op_full)
  );

  alu_execute alu_execute_inst (
    .op_data_i      (op_rd_data),
    .op_empty_i     (op_empty),
    .op_rd_valid_o  (op_rd_valid),
    .res_wr_valid_o (res_wr_valid),
    .res_data_o     (res_wr_data),
    .res_full_i     (res_full)
  );

  result_stage result_stage_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .res_wr_valid_i (res_wr_valid),
    .res_data_i     (res_wr_data),
    .res_full_o     (res_full),
    .out_req_o      (out_req_o),
    .out_res_o      (out_res_o),
    .out_ack_i      (out_ack_i)
  );

endmodule

// ==== tests/cmd_proc_properties.sv ====
`timescale 1ns/1ps

module cmd_proc_properties
  import cmd_proc_pkg::*;
(
  input logic             clk,
  input logic             rst_n,
  input logic             in_req_i,
  input logic             in_ack_i,
  input logic             out_req_i,
  input logic [RES_W-1:0] out_res_i,
  input logic             out_ack_i,
  input logic             op_wr_valid_i,
  input logic             op_rd_valid_i,
  input logic             res_wr_valid_i
);

  logic [3:0] op_count;
  logic [4:0] res_count;

  // Operation FIFO occupancy from its own writes and reads
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_count <= '0;
    end else begin
      op_count <= op_count + op_wr_valid_i - op_rd_valid_i;
    end
  end

  // Results written and not yet taken by the consumer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_count <= '0;
    end else begin
      res_count <= res_count + res_wr_valid_i - (out_req_i && out_ack_i);
    end
  end

  // Ack only answers a raised request
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    (!in_ack_i && !in_req_i) |=> !in_ack_i)
    else $error("in_ack_o rose while in_req_i was low");

  // Result word held while the consumer has not acked
  res_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_req_i && !out_ack_i) |=> $stable(out_res_i))
    else $error("out_res_o changed before out_ack_i");

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (out_req_i && !out_ack_i) |=> out_req_i)
    else $error("out_req_o fell before out_ack_i was high");

  op_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    op_wr_valid_i |-> (op_count < OP_FIFO_DEPTH))
    else $error("write into full operation FIFO");

  // The result held for the consumer has already left the FIFO
  res_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    res_wr_valid_i |-> ((res_count - out_req_i) < RES_FIFO_DEPTH))
    else $error("write into full result FIFO");

endmodule

bind cmd_proc cmd_proc_properties cmd_proc_properties_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .in_req_i       (in_req_i),
  .in_ack_i       (in_ack_o),
  .out_req_i      (out_req_o),
  .out_res_i      (out_res_o),
  .out_ack_i      (out_ack_i),
  .op_wr_valid_i  (op_wr_valid),
  .op_rd_valid_i  (op_rd_valid),
  .res_wr_valid_i (res_wr_valid)
);

// ==== tests/cmd_proc_tb.sv ====
`timescale 1ns/1ps

module cmd_proc_tb
  import cmd_proc_pkg::*;
();

  localparam int          CLK_PERIOD     = 20;
  localparam int          RESET_CYCLES   = 5;
  localparam int          TIMEOUT_CYCLES = 5000;
  localparam int unsigned SEED           = 32'hc490a412;

  logic             clk;
  logic             rst_n;
  logic             in_req;
  logic [CMD_W-1:0] in_cmd;
  logic             in_ack;
  logic             out_req;
  logic [RES_W-1:0] out_res;
  logic             out_ack;

  logic [CMD_W-1:0] cmd_q[$];
  logic [RES_W-1:0] expected_q[$];
  int               pass_count;
  int               fail_count;
  int               errors_at_start;
  int               acked_count;
  logic             in_ack_prev;
  int               cycle_count;
  string            test_name;

  cmd_proc cmd_proc_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_req_i  (in_req),
    .in_cmd_i  (in_cmd),
    .in_ack_o  (in_ack),
    .out_req_o (out_req),
    .out_res_o (out_res),
    .out_ack_i (out_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Run limit, about 70 commands at up to 40 cycles plus margin
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, test %s never finished", TIMEOUT_CYCLES, test_name);
    $display("TEST FAILED");
    $finish;
  end

  // Every rising edge of the command ack, seen apart from the host task
  always @(negedge clk) begin
    if (in_ack && !in_ack_prev) begin
      acked_count++;
    end
    in_ack_prev = in_ack;
  end

  // Expected result word built from the opcode rules
  function automatic logic [RES_W-1:0] model_result(input logic [CMD_W-1:0] cmd);
    int         a;
    int         b;
    int         r;
    logic       c;
    logic [7:0] d;
    a = int'(cmd[15:8]);
    b = int'(cmd[7:0]);
    c = 1'b0;
    case (cmd[19:16])
      4'd0: begin
        r = a + b;
        c = (r > 255);
      end
      4'd1: begin
        r = a - b + 256;
        c = (a < b);
      end
      4'd2:    r = int'(cmd[15:8] & cmd[7:0]);
      4'd3:    r = int'(cmd[15:8] | cmd[7:0]);
      4'd4:    r = int'(cmd[15:8] ^ cmd[7:0]);
      4'd5:    r = a * (1 << cmd[2:0]);
      4'd6:    r = a / (1 << cmd[2:0]);
      default: return {1'b1, 10'd0};
    endcase
    d = r[7:0];
    return {1'b0, c, (d == 8'd0), d};
  endfunction

  task automatic check_value(input string what, input logic [RES_W-1:0] expected,
                             input logic [RES_W-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: %s expected %b actual %b", test_name, what, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic add_cmd(input logic [3:0] opc, input logic [7:0] a, input logic [7:0] b);
    cmd_q.push_back({opc, a, b});
  endtask

  // Host side of the command handshake
  task automatic send_cmd(input logic [CMD_W-1:0] cmd);
    expected_q.push_back(model_result(cmd));
    @(negedge clk);
    in_cmd = cmd;
    in_req = 1'b1;
    while (!in_ack) @(negedge clk);
    in_req = 1'b0;
    while (in_ack) @(negedge clk);
  endtask

  // Consumer side, random ack delay between the two bounds
  task automatic collect_results(input int count, input int delay_min, input int delay_max);
    int delay;
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      while (!out_req) @(negedge clk);
      if (expected_q.size() == 0) begin
        $display("%s: result %h arrived with no command outstanding", test_name, out_res);
        fail_count++;
      end else begin
        check_value($sformatf("result %0d", i), expected_q.pop_front(), out_res);
      end
      delay = int'($urandom_range(delay_max, delay_min));
      repeat (delay) @(negedge clk);
      out_ack = 1'b1;
      while (out_req) @(negedge clk);
      out_ack = 1'b0;
    end
  endtask

  task automatic run_stream(input int delay_min, input int delay_max);
    int count;
    count = cmd_q.size();
    acked_count = 0;
    fork
      begin
        foreach (cmd_q[i]) send_cmd(cmd_q[i]);
      end
      collect_results(count, delay_min, delay_max);
    join
    if (acked_count != count) begin
      $display("%s: %0d acks seen for %0d commands", test_name, acked_count, count);
      fail_count++;
    end
    if (expected_q.size() != 0) begin
      $display("%s: %0d results never arrived", test_name, expected_q.size());
      fail_count++;
      expected_q.delete();
    end
    cmd_q.delete();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = fail_count;
  endtask

  task automatic finish_test();
    $display("%s finished with %0d errors", test_name, fail_count - errors_at_start);
  endtask

  task automatic test_reset();
    logic seen_req;
    start_test("reset");
    check_flag("in_ack_o after reset", 1'b0, in_ack);
    check_flag("out_req_o after reset", 1'b0, out_req);
    seen_req = 1'b0;
    repeat (20) begin
      @(negedge clk);
      seen_req = seen_req | out_req;
    end
    check_flag("out_req_o without command", 1'b0, seen_req);
    finish_test();
  endtask

  task automatic test_legal_ops();
    start_test("legal_ops");
    add_cmd({1'b0, OP_ADD}, 8'h00, 8'h00);
    add_cmd({1'b0, OP_ADD}, 8'h80, 8'h80);
    add_cmd({1'b0, OP_ADD}, 8'h3c, 8'h05);
    add_cmd({1'b0, OP_SUB}, 8'h55, 8'h55);
    add_cmd({1'b0, OP_SUB}, 8'h03, 8'h05);
    add_cmd({1'b0, OP_AND}, 8'hf0, 8'h0f);
    add_cmd({1'b0, OP_OR}, 8'ha0, 8'h05);
    add_cmd({1'b0, OP_XOR}, 8'h5a, 8'h5a);
    add_cmd({1'b0, OP_XOR}, 8'h5a, 8'hff);
    add_cmd({1'b0, OP_SHL}, 8'h81, 8'h01);
    add_cmd({1'b0, OP_SHL}, 8'h01, 8'h0f);
    add_cmd({1'b0, OP_SHR}, 8'h81, 8'h03);
    add_cmd({1'b0, OP_SHR}, 8'h01, 8'h09);
    run_stream(0, 0);
    finish_test();
  endtask

  task automatic test_illegal_ops();
    start_test("illegal_ops");
    add_cmd(4'd7, 8'h12, 8'h34);
    add_cmd(4'd12, 8'h00, 8'h00);
    add_cmd(4'd15, 8'hff, 8'hff);
    add_cmd({1'b0, OP_ADD}, 8'h12, 8'h34);
    run_stream(0, 2);
    finish_test();
  endtask

  // Slow consumer backs up both FIFOs into the host handshake
  task automatic test_back_pressure();
    start_test("back_pressure");
    for (int i = 0; i < 16; i++) begin
      add_cmd(4'(i % 7), 8'(i * 17), 8'(255 - i));
    end
    run_stream(30, 30);
    finish_test();
  endtask

  task automatic test_random_stream();
    start_test("random_stream");
    repeat (40) begin
      add_cmd(4'($urandom_range(15, 0)), 8'($urandom), 8'($urandom));
    end
    run_stream(0, 5);
    finish_test();
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n = 1'b0;
    in_req = 1'b0;
    in_cmd = '0;
    out_ack = 1'b0;
    pass_count = 0;
    fail_count = 0;
    acked_count = 0;
    in_ack_prev = 1'b0;
    test_name = "init";
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_legal_ops();
    test_illegal_ops();
    test_back_pressure();
    test_random_stream();
    $display("Checks passed %0d, checks failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== cmd_proc.f ====
source/cmd_proc_pkg.sv
source/fifo.sv
source/cmd_decode.sv
source/alu_execute.sv
source/result_stage.sv
source/cmd_proc.sv
tests/cmd_proc_properties.sv
tests/cmd_proc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cmd_proc testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f cmd_proc.f --top-module cmd_proc_tb \
  -o sim_cmd_proc \
  && ./obj_dir/sim_cmd_proc > sim.log 2>&1 \
  || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
